//--- common/primitivePkg.sv
// Shared widths, depths, port count and refill threshold for the primitive hub; referenced by scoped name
package primitivePkg;

   //==================================================
   // Port fan-out
   //==================================================
   localparam int PortCount   = 5;   // One primitive FIFO per port
   localparam int PortIdWidth = 3;   // Port number on the load stream

   //==================================================
   // Primitive storage
   //==================================================
   localparam int PrimitiveWidth = 64;    // One primitive word
   localparam int FifoDepth      = 256;   // Words per port FIFO

   // Fill level must count 0 up to a completely full FIFO,
   // so it needs one bit more than the pointer
   localparam int LevelWidth = 9;

   //==================================================
   // Refill policy
   //==================================================
   // During a burst a port asks for more primitives
   // while it holds fewer words than this
   localparam int RefillThreshold = 128;

endpackage

//--- primitiveBuffer/primitiveFifo.sv
// First-word-fall-through FIFO for one primitive port; wrap in primitiveBufferBank for each port
`timescale 1ns/100ps

module primitiveFifo #(
   parameter int Width = primitivePkg::PrimitiveWidth,
   parameter int Depth = primitivePkg::FifoDepth
) (
   input  logic                              OSC_50_BANK6,
   input  logic                              rstN,
   // Write side
   input  logic                              wrValid,
   output logic                              wrReady,
   input  logic [Width-1:0]                  wrData,
   // Read side, head word shown while rdValid is high
   output logic                              rdValid,
   input  logic                              rdReady,
   output logic [Width-1:0]                  rdData,
   // Words currently held
   output logic [primitivePkg::LevelWidth-1:0] level
);

   logic [Width-1:0]                     mem [Depth];
   logic [$clog2(Depth)-1:0]             wrPtr;
   logic [$clog2(Depth)-1:0]             rdPtr;
   logic [primitivePkg::LevelWidth-1:0]  count;
   logic                                 push;
   logic                                 pop;

   //==================================================
   // Handshake decode
   //==================================================
   assign wrReady = (count != Depth);   // Not full
   assign rdValid = (count != 0);       // Not empty
   assign push    = wrValid & wrReady;
   assign pop     = rdValid & rdReady;

   assign rdData = mem[rdPtr];          // Head word falls through
   assign level  = count;

   //==================================================
   // Storage array
   //==================================================
   always_ff @(posedge OSC_50_BANK6) begin
      if (push) begin
         mem[wrPtr] <= wrData;
      end
   end

   //==================================================
   // Pointers and occupancy
   //==================================================
   always_ff @(posedge OSC_50_BANK6) begin
      if (!rstN) begin
         wrPtr <= '0;
         rdPtr <= '0;
         count <= '0;
      end else begin
         if (push) begin
            if (wrPtr == Depth - 1) begin
               wrPtr <= '0;                 // Wrap to start of buffer
            end else begin
               wrPtr <= wrPtr + 1'b1;
            end
         end

         if (pop) begin
            if (rdPtr == Depth - 1) begin
               rdPtr <= '0;
            end else begin
               rdPtr <= rdPtr + 1'b1;
            end
         end

         // Simultaneous push and pop leave the level as it is
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

endmodule

//--- primitiveBuffer/primitiveBufferBank.sv
// Bank of per-port primitive FIFOs; steers the load stream by port number and exposes drains and levels
`timescale 1ns/100ps

module primitiveBufferBank (
   input  logic                                  OSC_50_BANK6,
   input  logic                                  rstN,

   // Load stream, one word for the port named by loadPort
   input  logic                                  loadValid,
   output logic                                  loadReady,
   input  logic [primitivePkg::PortIdWidth-1:0]  loadPort,
   input  logic [primitivePkg::PrimitiveWidth-1:0] loadData,

   // One drain stream per port
   output logic [primitivePkg::PortCount-1:0]    drainValid,
   input  logic [primitivePkg::PortCount-1:0]    drainReady,
   output logic [primitivePkg::PortCount-1:0][primitivePkg::PrimitiveWidth-1:0] drainData,

   // Fill levels toward the refill monitor
   output logic [primitivePkg::PortCount-1:0][primitivePkg::LevelWidth-1:0] fillLevel
);

   logic [primitivePkg::PortCount-1:0] fifoWrValid;
   logic [primitivePkg::PortCount-1:0] fifoWrReady;

   //==================================================
   // Load stream steering
   //==================================================
   // Only the addressed FIFO sees the valid
   always_comb begin
      for (int i = 0; i < primitivePkg::PortCount; i++) begin
         fifoWrValid[i] = loadValid && (loadPort == primitivePkg::PortIdWidth'(i));
      end
   end

   // Ready follows the addressed FIFO; an unknown port never matches
   always_comb begin
      loadReady = 1'b0;
      for (int i = 0; i < primitivePkg::PortCount; i++) begin
         if (loadPort == primitivePkg::PortIdWidth'(i)) begin
            loadReady = fifoWrReady[i];
         end
      end
   end

   //==================================================
   // Per-port FIFOs
   //==================================================
   for (genvar p = 0; p < primitivePkg::PortCount; p++) begin : gPort
      primitiveFifo #(
         .Width (primitivePkg::PrimitiveWidth),
         .Depth (primitivePkg::FifoDepth)
      ) portFifo (
         .OSC_50_BANK6 (OSC_50_BANK6),
         .rstN         (rstN),
         .wrValid      (fifoWrValid[p]),
         .wrReady      (fifoWrReady[p]),
         .wrData       (loadData),        // Shared bus, valid selects the target
         .rdValid      (drainValid[p]),
         .rdReady      (drainReady[p]),
         .rdData       (drainData[p]),
         .level        (fillLevel[p])
      );
   end

endmodule

//--- hw/burstSignaller.sv
// Registers the burst control bit and marks Start and End of Burst on the ECRST/BCRST pair
`timescale 1ns/100ps

module burstSignaller (
   input  logic OSC_50_BANK6,
   input  logic rstN,
   input  logic burst,      // Burst control bit from the run controller
   output logic inBurst,    // Registered copy of burst
   output logic ecrst,
   output logic bcrst
);

   logic burstRise;
   logic burstFall;

   // Compare incoming level with the registered one
   assign burstRise =  burst & ~inBurst;
   assign burstFall = ~burst &  inBurst;

   //==================================================
   // Burst state and marker codes
   //==================================================
   // Start of Burst  ecrst=1 bcrst=1
   // End of Burst    ecrst=1 bcrst=0
   // Idle            both low
   always_ff @(posedge OSC_50_BANK6) begin
      if (!rstN) begin
         inBurst <= 1'b0;
         ecrst   <= 1'b0;
         bcrst   <= 1'b0;
      end else begin
         inBurst <= burst;
         ecrst   <= burstRise | burstFall;   // High on either edge
         bcrst   <= burstRise;               // Only for start
      end
   end

endmodule

//--- hw/refillMonitor.sv
// Produces the registered per-port refill-request vector from fill levels, burst state and init bits
`timescale 1ns/100ps

module refillMonitor (
   input  logic                                OSC_50_BANK6,
   input  logic                                rstN,
   input  logic [primitivePkg::PortCount-1:0][primitivePkg::LevelWidth-1:0] fillLevel,
   input  logic                                inBurst,
   input  logic [primitivePkg::PortCount-1:0]  detectorUnderInit,
   output logic [primitivePkg::PortCount-1:0]  refillRequest
);

   logic [primitivePkg::PortCount-1:0] belowThreshold;

   // Port running low on primitives
   always_comb begin
      for (int i = 0; i < primitivePkg::PortCount; i++) begin
         belowThreshold[i] = (fillLevel[i] < primitivePkg::RefillThreshold);
      end
   end

   //==================================================
   // Request register
   //==================================================
   always_ff @(posedge OSC_50_BANK6) begin
      if (!rstN) begin
         refillRequest <= '0;
      end else if (inBurst) begin
         refillRequest <= belowThreshold;      // Keep FIFOs topped up
      end else begin
         refillRequest <= detectorUnderInit;   // Between bursts follow init state
      end
   end

endmodule

//--- hw/primitiveHub.sv
// Top level of the primitive distribution core; instantiate on the board or under the testbench
`timescale 1ns/100ps

module primitiveHub (
   input  logic                                  OSC_50_BANK6,
   input  logic                                  rstN,

   //==================================================
   // Load stream
   //==================================================
   input  logic                                  loadValid,
   output logic                                  loadReady,
   input  logic [primitivePkg::PortIdWidth-1:0]  loadPort,
   input  logic [primitivePkg::PrimitiveWidth-1:0] loadData,

   //==================================================
   // Drain streams, one per port
   //==================================================
   output logic [primitivePkg::PortCount-1:0]    drainValid,
   input  logic [primitivePkg::PortCount-1:0]    drainReady,
   output logic [primitivePkg::PortCount-1:0][primitivePkg::PrimitiveWidth-1:0] drainData,

   //==================================================
   // Run control and refill requests
   //==================================================
   input  logic                                  burst,
   input  logic [primitivePkg::PortCount-1:0]    detectorUnderInit,
   output logic [primitivePkg::PortCount-1:0]    refillRequest,
   output logic                                  ECRST,   // Burst marker pair
   output logic                                  BCRST
);

   logic [primitivePkg::PortCount-1:0][primitivePkg::LevelWidth-1:0] fillLevel;
   logic inBurst;

   // Storage side
   primitiveBufferBank bank (
      .OSC_50_BANK6 (OSC_50_BANK6),
      .rstN         (rstN),
      .loadValid    (loadValid),
      .loadReady    (loadReady),
      .loadPort     (loadPort),
      .loadData     (loadData),
      .drainValid   (drainValid),
      .drainReady   (drainReady),
      .drainData    (drainData),
      .fillLevel    (fillLevel)
   );

   // Burst edges, runs alongside the bank
   burstSignaller signaller (
      .OSC_50_BANK6 (OSC_50_BANK6),
      .rstN         (rstN),
      .burst        (burst),
      .inBurst      (inBurst),
      .ecrst        (ECRST),
      .bcrst        (BCRST)
   );

   // Combines levels and burst state
   refillMonitor monitor (
      .OSC_50_BANK6      (OSC_50_BANK6),
      .rstN              (rstN),
      .fillLevel         (fillLevel),
      .inBurst           (inBurst),
      .detectorUnderInit (detectorUnderInit),
      .refillRequest     (refillRequest)
   );

endmodule

//--- test/primitiveHubTb.sv
// Self-checking testbench for primitiveHub; run from the project root so the pattern file is found
`timescale 1ns/100ps

module primitiveHubTb;

   localparam int MaxSteps   = 64;
   localparam int StepFields = 7;                              // Hex fields per pattern step
   localparam int TrackDepth = 512;                            // Record of sent words per port
   localparam int StallLimit = 4 * primitivePkg::FifoDepth;

   logic                                        OSC_50_BANK6;
   logic                                        rstN;
   logic                                        loadValid;
   logic                                        loadReady;
   logic [primitivePkg::PortIdWidth-1:0]        loadPort;
   logic [primitivePkg::PrimitiveWidth-1:0]     loadData;
   logic [primitivePkg::PortCount-1:0]          drainValid;
   logic [primitivePkg::PortCount-1:0]          drainReady;
   logic [primitivePkg::PortCount-1:0][primitivePkg::PrimitiveWidth-1:0] drainData;
   logic                                        burst;
   logic [primitivePkg::PortCount-1:0]          detectorUnderInit;
   logic [primitivePkg::PortCount-1:0]          refillRequest;
   logic                                        ECRST;
   logic                                        BCRST;

   logic [31:0]                             patternMem [MaxSteps*StepFields];
   logic [primitivePkg::PrimitiveWidth-1:0] sentWords [primitivePkg::PortCount][TrackDepth];
   int                                      sentHead [primitivePkg::PortCount];
   int                                      sentTail [primitivePkg::PortCount];
   integer                                  seed;
   int                                      errorCount;
   int                                      testCount;
   int                                      failedTests;
   longint                                  limitNs;
   string                                   testName;
   logic                                    markCheckOn;
   logic                                    modelInBurst;   // Burst bit as the DUT should hold it
   logic [1:0]                              expMark;        // Expected {ECRST, BCRST}

   primitiveHub dut (
      .OSC_50_BANK6      (OSC_50_BANK6),
      .rstN              (rstN),
      .loadValid         (loadValid),
      .loadReady         (loadReady),
      .loadPort          (loadPort),
      .loadData          (loadData),
      .drainValid        (drainValid),
      .drainReady        (drainReady),
      .drainData         (drainData),
      .burst             (burst),
      .detectorUnderInit (detectorUnderInit),
      .refillRequest     (refillRequest),
      .ECRST             (ECRST),
      .BCRST             (BCRST)
   );

   initial OSC_50_BANK6 = 1'b0;
   always #4 OSC_50_BANK6 = ~OSC_50_BANK6;   // 8 ns period

   //==================================================
   // Compare tasks
   //==================================================
   task automatic checkPrimitive(input string name,
                                 input logic [primitivePkg::PrimitiveWidth-1:0] expected,
                                 input logic [primitivePkg::PrimitiveWidth-1:0] actual);
      if (actual !== expected) begin
         errorCount++;
         $display("error %s: expected %h, actual %h", name, expected, actual);
      end
   endtask

   task automatic checkRefill(input string name,
                              input logic [primitivePkg::PortCount-1:0] expected,
                              input logic [primitivePkg::PortCount-1:0] actual);
      if (actual !== expected) begin
         errorCount++;
         $display("error %s refill: expected %b, actual %b", name, expected, actual);
      end
   endtask

   task automatic checkBurstMark(input string name, input logic [1:0] expected,
                                 input logic [1:0] actual);
      if (actual !== expected) begin
         errorCount++;
         $display("error %s ecrst/bcrst: expected %b, actual %b", name, expected, actual);
      end
   endtask

   task automatic checkHandshake(input string name, input logic expected, input logic actual);
      if (actual !== expected) begin
         errorCount++;
         $display("error %s: expected %b, actual %b", name, expected, actual);
      end
   endtask

   task automatic reportFault(input string what);
      errorCount++;
      $display("%s: %s", testName, what);
   endtask

   function automatic int heldWords(input int p);
      return sentTail[p] - sentHead[p];
   endfunction

   function automatic string kindName(input int code);
      case (code)
         1:       return "reset state";
         2:       return "order per port";
         3:       return "back-pressure";
         4:       return "refill in burst";
         5:       return "refill outside burst";
         6:       return "burst marks";
         default: return "unknown";
      endcase
   endfunction

   //==================================================
   // Stream drivers and reference queues
   //==================================================
   // Drain side is checked before the load is recorded because a fresh word cannot leave yet
   task automatic runCycle(output bit loaded);
      @(negedge OSC_50_BANK6);
      for (int p = 0; p < primitivePkg::PortCount; p++) begin
         if (drainValid[p] && drainReady[p]) begin
            if (heldWords(p) == 0) begin
               reportFault($sformatf("port %0d delivered a word that was never loaded", p));
            end else begin
               checkPrimitive($sformatf("%s port %0d", testName, p),
                              sentWords[p][sentHead[p] % TrackDepth], drainData[p]);
               sentHead[p]++;
            end
         end
      end
      loaded = loadValid && loadReady;
      if (loaded) begin
         sentWords[loadPort][sentTail[loadPort] % TrackDepth] = loadData;
         sentTail[loadPort]++;
      end
      @(posedge OSC_50_BANK6);
      #1;
   endtask

   task automatic idleCycles(input int n);
      bit loaded;
      repeat (n) runCycle(loaded);
   endtask

   task automatic loadWords(input int port, input int count, input bit randomPort,
                            input bit randomDrain);
      bit loaded;
      int stall;
      for (int n = 0; n < count; n++) begin
         loadValid = 1'b1;
         if (randomPort) begin
            loadPort = primitivePkg::PortIdWidth'({$random(seed)} % primitivePkg::PortCount);
         end else begin
            loadPort = primitivePkg::PortIdWidth'(port);
         end
         loadData = {$random(seed), $random(seed)};
         loaded   = 1'b0;
         stall    = 0;
         while (!loaded && stall < StallLimit) begin
            if (randomDrain) drainReady = primitivePkg::PortCount'($random(seed));
            runCycle(loaded);
            stall++;
         end
         if (!loaded) begin
            reportFault($sformatf("load stream stalled, word %0d never accepted", n));
            break;
         end
      end
      loadValid = 1'b0;
   endtask

   task automatic drainAll();
      bit loaded;
      int waitCycles;
      int pending;
      loadValid  = 1'b0;
      drainReady = '1;
      waitCycles = 0;
      pending    = 0;
      for (int p = 0; p < primitivePkg::PortCount; p++) pending += heldWords(p);
      while (pending > 0 && waitCycles < StallLimit) begin
         runCycle(loaded);
         waitCycles++;
         pending = 0;
         for (int p = 0; p < primitivePkg::PortCount; p++) pending += heldWords(p);
      end
      if (pending > 0) reportFault($sformatf("drain stalled with %0d words held", pending));
      runCycle(loaded);   // Any extra word shows up here
      if (drainValid !== '0) reportFault("drain streams still valid after all words returned");
   endtask

   task automatic probeReady(input int p, input logic expected);
      loadPort = primitivePkg::PortIdWidth'(p);
      @(negedge OSC_50_BANK6);
      checkHandshake($sformatf("%s loadReady port %0d", testName, p), expected, loadReady);
      @(posedge OSC_50_BANK6);
      #1;
   endtask

   task automatic sampleRefill(input logic [primitivePkg::PortCount-1:0] expected);
      @(negedge OSC_50_BANK6);
      checkRefill(testName, expected, refillRequest);
      @(posedge OSC_50_BANK6);
      #1;
   endtask

   //==================================================
   // Reset and burst marks
   //==================================================
   task automatic applyReset();
      rstN       = 1'b0;
      loadValid  = 1'b0;
      drainReady = '0;
      burst      = 1'b0;
      repeat (2) @(posedge OSC_50_BANK6);
      #1;
      rstN = 1'b1;
      for (int p = 0; p < primitivePkg::PortCount; p++) begin
         sentHead[p] = 0;
         sentTail[p] = 0;
      end
   endtask

   task automatic checkResetState();
      // Held words and raised requests that only a working reset clears
      drainReady        = '0;
      detectorUnderInit = '1;
      loadWords(0, 4, 1'b0, 1'b0);
      idleCycles(1);
      applyReset();
      @(negedge OSC_50_BANK6);
      for (int p = 0; p < primitivePkg::PortCount; p++) begin
         checkHandshake($sformatf("%s drainValid[%0d]", testName, p), 1'b0, drainValid[p]);
      end
      checkHandshake({testName, " loadReady"}, 1'b1, loadReady);
      checkRefill(testName, '0, refillRequest);
      checkBurstMark(testName, 2'b00, {ECRST, BCRST});
      @(posedge OSC_50_BANK6);
      #1;
      detectorUnderInit = '0;
   endtask

   task automatic countMarks(input logic burstVal);
      int startMarks;
      int endMarks;
      int wantStart;
      int wantEnd;
      wantStart  = (burstVal && !burst) ? 1 : 0;
      wantEnd    = (!burstVal && burst) ? 1 : 0;
      startMarks = 0;
      endMarks   = 0;
      burst      = burstVal;
      repeat (4) begin
         @(negedge OSC_50_BANK6);
         if (ECRST === 1'b1 && BCRST === 1'b1) startMarks++;
         if (ECRST === 1'b1 && BCRST === 1'b0) endMarks++;
         @(posedge OSC_50_BANK6);
         #1;
      end
      if (startMarks != wantStart || endMarks != wantEnd) begin
         reportFault($sformatf("saw %0d start and %0d end marks where %0d and %0d belong",
                               startMarks, endMarks, wantStart, wantEnd));
      end
   endtask

   // Start of Burst on a rising burst bit, End of Burst on a falling one
   always @(posedge OSC_50_BANK6) begin
      if (!rstN) begin
         modelInBurst = 1'b0;
         expMark      = 2'b00;
      end else begin
         expMark      = {burst ^ modelInBurst, burst & ~modelInBurst};
         modelInBurst = burst;
      end
   end

   always @(negedge OSC_50_BANK6) begin
      if (markCheckOn) checkBurstMark({testName, " idle"}, expMark, {ECRST, BCRST});
   end

   //==================================================
   // Step sequencer
   //==================================================
   task automatic runStep(input int idx);
      int                                 base;
      int                                 code;
      int                                 port;
      int                                 count;
      int                                 errorsBefore;
      logic                               burstVal;
      logic [primitivePkg::PortCount-1:0] detVal;
      logic [primitivePkg::PortCount-1:0] fileRefill;
      logic [primitivePkg::PortCount-1:0] ruleRefill;
      base         = idx * StepFields;
      code         = patternMem[base];
      port         = patternMem[base+1];
      count        = patternMem[base+2];
      burstVal     = patternMem[base+4][0];
      detVal       = patternMem[base+5][primitivePkg::PortCount-1:0];
      fileRefill   = patternMem[base+6][primitivePkg::PortCount-1:0];
      testName     = $sformatf("step %0d %s", idx, kindName(code));
      errorsBefore = errorCount;
      case (code)
         1: checkResetState();
         2: begin
            burst = burstVal;
            idleCycles(3);
            seed = seed + patternMem[base+3];
            loadWords(0, count, 1'b1, 1'b1);
            drainAll();
         end
         3: begin
            burst            = burstVal;
            drainReady       = '1;
            drainReady[port] = 1'b0;   // Stalled sink lets this FIFO fill
            idleCycles(3);
            loadWords(port, count, 1'b0, 1'b0);
            for (int p = 0; p < primitivePkg::PortCount; p++) begin
               probeReady(p, !(p == port && heldWords(p) >= primitivePkg::FifoDepth));
            end
            drainAll();
         end
         4, 5: begin
            burst      = burstVal;
            drainReady = '0;
            idleCycles(3);
            loadWords(port, count, 1'b0, 1'b0);
            detectorUnderInit = detVal;
            idleCycles(2);
            for (int p = 0; p < primitivePkg::PortCount; p++) begin
               ruleRefill[p] = burstVal ? (heldWords(p) < primitivePkg::RefillThreshold)
                                        : detVal[p];
            end
            sampleRefill(ruleRefill);
            if (ruleRefill !== fileRefill) begin
               reportFault($sformatf("pattern file lists refill %b but the level rule gives %b",
                                     fileRefill, ruleRefill));
            end
            drainAll();
         end
         6: countMarks(burstVal);
         default: reportFault("pattern step has an unknown test code");
      endcase
      testCount++;
      if (errorCount > errorsBefore) failedTests++;
      $display("test %s finished with %0d errors", testName, errorCount - errorsBefore);
   endtask

   // Watchdog sized from the pattern file once it is read
   initial begin
      wait (limitNs > 0);
      #(limitNs);
      $display("watchdog: run still busy after %0d ns, stopping", limitNs);
      $display("FAIL: see errors above");
      $finish;
   end

   initial begin
      longint budget;
      int     steps;
      seed              = 32'ha613;
      errorCount        = 0;
      testCount         = 0;
      failedTests       = 0;
      limitNs           = 0;
      markCheckOn       = 1'b0;
      rstN              = 1'b0;
      loadValid         = 1'b0;
      loadPort          = '0;
      loadData          = '0;
      drainReady        = '0;
      burst             = 1'b0;
      detectorUnderInit = '0;
      $readmemh("test/primitivePatterns.txt", patternMem);
      steps  = 0;
      budget = 0;
      while (steps < MaxSteps && !$isunknown(patternMem[steps*StepFields]) &&
             patternMem[steps*StepFields] != 0) begin
         budget += patternMem[steps*StepFields+2] + 20;
         steps++;
      end
      limitNs = budget * 8 * 4;
      if (steps == 0) reportFault("pattern file holds no test steps");
      applyReset();
      markCheckOn = 1'b1;
      for (int s = 0; s < steps; s++) runStep(s);
      $display("summary: %0d tests, %0d failed, %0d errors", testCount, failedTests, errorCount);
      if (errorCount == 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

endmodule

//--- src.f
common/primitivePkg.sv
primitiveBuffer/primitiveFifo.sv
primitiveBuffer/primitiveBufferBank.sv
hw/burstSignaller.sv
hw/refillMonitor.sv
hw/primitiveHub.sv
test/primitiveHubTb.sv

//--- test/primitivePatterns.txt
// Test steps, seven hex fields each:
// code port wordCount seedOffset burst detectorInit expectedRefill
// Codes: 1 reset, 2 mixed order, 3 back-pressure, 4 refill in burst,
//        5 refill outside burst, 6 burst mark, 0 ends the list

// Reset and idle state
1 0 000 00 0 00 00

// Mixed ports with random drain readiness
2 0 040 01 0 00 00
2 0 060 17 0 00 00
2 0 030 2c 1 00 00
2 0 080 05 0 00 00
2 0 020 3e 1 00 00

// Back-pressure, full FIFO refuses its port only
3 2 100 00 0 00 00
3 0 100 00 0 00 00
3 4 0ff 00 0 00 00
3 1 100 00 1 00 00

// Burst marks on rising and falling burst bit
6 0 000 00 1 00 00
6 0 000 00 1 00 00
6 0 000 00 0 00 00
6 0 000 00 0 00 00
6 0 000 00 1 00 00
6 0 000 00 0 00 00

// Refill rule inside a burst
// Threshold crossing at 127 and 128 words
4 1 07f 00 1 00 1f
4 1 080 00 1 00 1d
4 0 07f 00 1 00 1f
4 0 080 00 1 00 1e
// Deeper fills and an empty bank
4 3 0c8 00 1 00 17
4 4 100 00 1 00 0f
4 2 000 00 1 00 1f
4 2 081 00 1 0a 1b

// Between bursts refill mirrors detector init
5 0 000 00 0 0a 0a
5 3 0c8 00 0 15 15
5 0 080 00 0 00 00
5 1 07f 00 0 1f 1f
5 4 100 00 0 11 11
5 2 040 00 0 04 04

// Mark after a refill step left burst low
6 0 000 00 1 00 00
4 3 07f 00 1 00 1f
6 0 000 00 0 00 00

// Second reset in the middle of the run
1 0 000 00 0 00 00
2 0 050 33 0 00 00

// End of list
0 0 000 00 0 00 00
